// File: list.f
+incdir+dv
hw/rv_core_pkg.sv
hw/regfile.sv
hw/alu.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/rv_core.sv
dv/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
BUILD_DIR ?= build

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f list.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// Architectural registers with entry 0 never written
word_t model_regs [32];

function automatic void model_clear();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
endfunction

function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// Logical shift with the vacated bits filled by the sign for SRA
function automatic word_t shift_right(word_t a, logic [4:0] sh, logic arith);
    word_t fill;
    fill = (arith && a[31]) ? ~(32'hFFFF_FFFF >> sh) : '0;
    return (a >> sh) | fill;
endfunction

function automatic void model_step(input logic valid, input word_t instr,
                                   output logic wb, output reg_addr_t rd,
                                   output word_t data);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       legal;
    logic       alt;
    word_t      a;
    word_t      b;
    opc = instr[6:0];
    f3  = instr[14:12];
    f7  = instr[31:25];
    rd  = instr[11:7];
    a   = model_regs[instr[19:15]];
    alt = (f7 == 7'h20);
    if (opc == OPC_OP) begin
        b     = model_regs[instr[24:20]];
        legal = (f7 == 7'h00) || (alt && ((f3 == 3'b000) || (f3 == 3'b101)));
    end else begin
        b     = sext12(instr[31:20]);
        legal = (opc == OPC_OP_IMM) &&
                (((f3 != 3'b001) && (f3 != 3'b101)) || (f7 == 7'h00) ||
                 (alt && (f3 == 3'b101)));
        // Bit 30 selects only SRAI and never turns ADDI into a subtract
        alt   = alt && (f3 == 3'b101);
    end
    case (f3)
        3'b000:  data = alt ? (a - b) : (a + b);
        3'b001:  data = a << b[4:0];
        3'b010:  data = {31'b0, ((a[31] != b[31]) ? a[31] : (a < b))};
        3'b011:  data = {31'b0, (a < b)};
        3'b100:  data = a ^ b;
        3'b101:  data = shift_right(a, b[4:0], alt);
        3'b110:  data = a | b;
        default: data = a & b;
    endcase
    wb = valid && legal && (rd != '0);
    if (wb) begin
        model_regs[rd] = data;
    end
endfunction

`endif

// File: dv/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    `include "rv_model.svh"

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int SEED           = 88649;
    localparam int N_RANDOM       = 2000;
    localparam int N_DIRECTED_MAX = 1000;
    localparam int WD_MARGIN      = 200;
    localparam int WATCHDOG_NS    =
        (RESET_CYCLES + N_DIRECTED_MAX + N_RANDOM + WD_MARGIN) * CLK_PERIOD;

    typedef struct packed {
        int        due;
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_exp_t;

    logic      i_clk;
    logic      i_reset;
    logic      i_instr_valid;
    word_t     i_instr;
    logic      o_wb_valid;
    reg_addr_t o_wb_rd;
    word_t     o_wb_data;

    wb_exp_t exp_q [$];
    int      cycle_count = 0;
    int      n_checks    = 0;
    int      n_errors    = 0;
    int      n_tests     = 0;
    int      checks_mark = 0;
    int      errors_mark = 0;

    rv_core DUT (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic logic [9:0] rr_funct(alu_op_e op);
        case (op)
            SUB:     return {7'h20, 3'b000};
            SLL:     return {7'h00, 3'b001};
            SLT:     return {7'h00, 3'b010};
            SLTU:    return {7'h00, 3'b011};
            XOR:     return {7'h00, 3'b100};
            SRL:     return {7'h00, 3'b101};
            SRA:     return {7'h20, 3'b101};
            OR:      return {7'h00, 3'b110};
            AND:     return {7'h00, 3'b111};
            default: return {7'h00, 3'b000};
        endcase
    endfunction

    function automatic word_t enc_r(alu_op_e op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        logic [9:0] f;
        f = rr_funct(op);
        return {f[9:3], rs2, rs1, f[2:0], rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // Mostly x0..x7 so that dependencies are frequent
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(3, 0) != 0) begin
            return reg_addr_t'($urandom_range(7, 0));
        end
        return reg_addr_t'($urandom_range(31, 0));
    endfunction

    function automatic word_t rand_imm(reg_addr_t rd, reg_addr_t rs1);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3  = 3'($urandom_range(7, 0));
        imm = 12'($urandom);
        if (f3 == 3'b001) begin
            imm[11:5] = 7'h00;
        end
        if (f3 == 3'b101) begin
            imm[11:5] = ($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        end
        return enc_i(imm, rs1, f3, rd);
    endfunction

    function automatic word_t rand_legal(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        if ($urandom_range(1, 0) == 0) begin
            return enc_r(alu_op_e'($urandom_range(9, 0)), rd, rs1, rs2);
        end
        return rand_imm(rd, rs1);
    endfunction

    // Load opcode, M-extension funct7, or SLLI with bad upper bits
    function automatic word_t rand_illegal();
        word_t w;
        w = $urandom;
        case ($urandom_range(2, 0))
            0: w[6:0] = 7'b0000011;
            1: begin
                w[31:25] = 7'h01;
                w[6:0]   = OPC_OP;
            end
            default: begin
                w[31:25] = 7'h10;
                w[14:12] = 3'b001;
                w[6:0]   = OPC_OP_IMM;
            end
        endcase
        return w;
    endfunction

    task automatic present(input logic valid, input word_t instr);
        wb_exp_t e;
        logic    wb;
        reg_addr_t rd;
        word_t   data;
        @(posedge i_clk);
        cycle_count++;
        i_instr_valid <= valid;
        i_instr       <= instr;
        model_step(valid, instr, wb, rd, data);
        e.due   = cycle_count + 3;
        e.valid = wb;
        e.rd    = rd;
        e.data  = data;
        exp_q.push_back(e);
    endtask

    task automatic present_random();
        int kind;
        kind = int'($urandom_range(99, 0));
        if (kind < 70) begin
            present(1'b1, rand_legal(pick_reg(), pick_reg(), pick_reg()));
        end else if (kind < 80) begin
            present(1'b0, rand_legal(pick_reg(), pick_reg(), pick_reg()));
        end else if (kind < 90) begin
            present(1'b1, rand_illegal());
        end else begin
            present(1'b1, rand_legal(5'd0, pick_reg(), pick_reg()));
        end
    endtask

    // 32-bit constant from 11 + 11 + 10 bit chunks
    task automatic load_reg(input reg_addr_t rd, input word_t v);
        present(1'b1, enc_i({1'b0, v[31:21]}, 5'd0, 3'b000, rd));
        present(1'b1, enc_i(12'd11, rd, 3'b001, rd));
        present(1'b1, enc_i({1'b0, v[20:10]}, rd, 3'b110, rd));
        present(1'b1, enc_i(12'd10, rd, 3'b001, rd));
        present(1'b1, enc_i({2'b0, v[9:0]}, rd, 3'b110, rd));
    endtask

    task automatic end_test(input string name);
        int last_cycle;
        last_cycle = cycle_count + 4;
        while (cycle_count < last_cycle) begin
            present(1'b0, '0);
        end
        $display("%s: %0d checks, %0d errors", name, n_checks - checks_mark,
                 n_errors - errors_mark);
        checks_mark = n_checks;
        errors_mark = n_errors;
        n_tests++;
    endtask

    task automatic check_writeback();
        wb_exp_t e;
        e = '0;
        if ((exp_q.size() > 0) && (exp_q[0].due == cycle_count)) begin
            e = exp_q.pop_front();
        end
        n_checks++;
        assert (o_wb_valid === e.valid) else begin
            n_errors++;
            $display("Fail at time %0t: o_wb_valid is %b, expected %b",
                     $time, o_wb_valid, e.valid);
        end
        if (e.valid && o_wb_valid) begin
            assert ((o_wb_rd === e.rd) && (o_wb_data === e.data)) else begin
                n_errors++;
                $display("Fail at time %0t: wrote x%0d = %h, expected x%0d = %h",
                         $time, o_wb_rd, o_wb_data, e.rd, e.data);
            end
        end
    endtask

    // Outputs are settled half a cycle after the edge
    always @(negedge i_clk) begin
        if (cycle_count > 0) begin
            check_writeback();
        end
    end

    task automatic reset_reads();
        repeat (6) present(1'b0, '0);
        for (int r = 1; r < 32; r++) begin
            present(1'b1, enc_r(OR, reg_addr_t'(r), reg_addr_t'(r), 5'd0));
        end
        end_test("reset and fresh reads");
    endtask

    task automatic independent_imm();
        for (int r = 16; r < 32; r++) begin
            load_reg(reg_addr_t'(r), $urandom);
        end
        repeat (3) present(1'b0, '0);
        repeat (48) begin
            present(1'b1, rand_imm(reg_addr_t'($urandom_range(15, 1)),
                                   reg_addr_t'($urandom_range(31, 16))));
        end
        end_test("independent immediates");
    endtask

    task automatic alu_op_sweep();
        load_reg(5'd1, 32'hFFFF_FFFB);
        load_reg(5'd2, 32'h0000_0003);
        load_reg(5'd3, 32'h8000_0000);
        load_reg(5'd4, 32'h7FFF_FFFF);
        load_reg(5'd5, $urandom);
        load_reg(5'd6, 32'h0000_0024);
        for (int op = 0; op < 10; op++) begin
            for (int a = 1; a <= 6; a++) begin
                for (int b = 1; b <= 6; b++) begin
                    present(1'b1, enc_r(alu_op_e'(op), reg_addr_t'(8 + (a + b) % 8),
                                        reg_addr_t'(a), reg_addr_t'(b)));
                end
            end
        end
        end_test("register ALU ops");
    endtask

    task automatic forwarding_paths();
        load_reg(5'd1, $urandom);
        load_reg(5'd4, $urandom);
        // Each result feeds the very next instruction
        repeat (12) present(1'b1, rand_legal(5'd1, 5'd1, 5'd4));
        // Consumer two slots behind its producer
        repeat (12) begin
            present(1'b1, rand_legal(5'd2, 5'd1, 5'd4));
            present(1'b1, enc_r(XOR, 5'd3, 5'd4, 5'd4));
            present(1'b1, enc_r(ADD, 5'd1, 5'd2, 5'd1));
        end
        repeat (60) begin
            present(1'b1, rand_legal(reg_addr_t'($urandom_range(3, 1)),
                                     reg_addr_t'($urandom_range(3, 1)),
                                     reg_addr_t'($urandom_range(3, 1))));
        end
        end_test("forwarding");
    endtask

    task automatic suppressed_writes();
        repeat (10) present(1'b1, rand_legal(5'd0, pick_reg(), pick_reg()));
        repeat (10) begin
            present(1'b0, rand_legal(reg_addr_t'($urandom_range(31, 1)),
                                     pick_reg(), pick_reg()));
        end
        repeat (20) present(1'b1, rand_illegal());
        // A stray write above would show up as a changed register
        for (int r = 1; r < 32; r++) begin
            present(1'b1, enc_i(12'h000, reg_addr_t'(r), 3'b000, reg_addr_t'(r)));
        end
        repeat (4) present(1'b1, enc_r(OR, 5'd9, 5'd0, 5'd0));
        end_test("suppressed writebacks");
    endtask

    task automatic random_mix();
        repeat (N_RANDOM) present_random();
        end_test("random mix");
    endtask

    initial begin
        i_reset       = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        void'($urandom(SEED));
        model_clear();
        repeat (RESET_CYCLES) begin
            @(posedge i_clk);
            cycle_count++;
        end
        i_reset <= 1'b0;
        reset_reads();
        independent_imm();
        alu_op_sweep();
        forwarding_paths();
        suppressed_writes();
        random_mix();
        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_instr_valid,
    input  rv_core_pkg::word_t     i_instr,
    output logic                  o_wb_valid,
    output rv_core_pkg::reg_addr_t o_wb_rd,
    output rv_core_pkg::word_t     o_wb_data
);
    import rv_core_pkg::*;

    id_ex_t id_ex;
    ex_wb_t ex_wb;

    decode_stage u_decode (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_wb          (ex_wb),
        .o_id_ex       (id_ex)
    );

    execute_stage u_execute (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_id_ex (id_ex),
        .o_ex_wb (ex_wb)
    );

    // Writeback register drives the outputs directly
    assign o_wb_valid = ex_wb.valid;
    assign o_wb_rd    = ex_wb.rd;
    assign o_wb_data  = ex_wb.result;

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic               i_clk,
    input  logic               i_reset,
    input  rv_core_pkg::id_ex_t i_id_ex,
    output rv_core_pkg::ex_wb_t o_ex_wb
);
    import rv_core_pkg::*;

    ex_wb_t ex_wb_d;
    ex_wb_t ex_wb_q;
    word_t  src_a;
    word_t  rs2_fwd;
    word_t  src_b;
    word_t  alu_result;

    // Result of the previous instruction bypasses the register file
    function automatic word_t forward(reg_addr_t rs, word_t rf_data, ex_wb_t wb);
        if (wb.valid && (wb.rd != '0) && (wb.rd == rs)) begin
            return wb.result;
        end
        return rf_data;
    endfunction

    always_comb begin
        src_a   = forward(i_id_ex.rs1, i_id_ex.rs1_data, ex_wb_q);
        rs2_fwd = forward(i_id_ex.rs2, i_id_ex.rs2_data, ex_wb_q);
        src_b   = i_id_ex.use_imm ? i_id_ex.imm : rs2_fwd;
    end

    alu u_alu (
        .i_op     (i_id_ex.alu_op),
        .i_a      (src_a),
        .i_b      (src_b),
        .o_result (alu_result)
    );

    always_comb begin
        ex_wb_d.valid  = i_id_ex.valid;
        ex_wb_d.rd     = i_id_ex.rd;
        ex_wb_d.result = alu_result;
    end

    always_ff @(posedge i_clk) begin
        ex_wb_q <= ex_wb_d;
        if (i_reset) begin
            ex_wb_q.valid <= 1'b0;
        end
    end

    assign o_ex_wb = ex_wb_q;

    // Bubbles for x0 are made back in decode
    a_wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
        o_ex_wb.valid |-> (o_ex_wb.rd != '0));

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_instr_valid,
    input  rv_core_pkg::word_t   i_instr,
    input  rv_core_pkg::ex_wb_t  i_wb,
    output rv_core_pkg::id_ex_t  o_id_ex
);
    import rv_core_pkg::*;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    instr_u     instr_q;
    logic       instr_valid_q;
    logic       supported;
    logic       use_imm;
    alu_op_e    alu_op;
    logic [6:0] shift_hi;
    reg_addr_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;

    always_ff @(posedge i_clk) begin
        instr_q <= i_instr;
        if (i_reset) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= i_instr_valid;
        end
    end

    // Upper immediate bits qualify the shift-immediate forms
    assign shift_hi = instr_q.i.imm12[11:5];

    always_comb begin
        supported = 1'b0;
        use_imm   = 1'b0;
        alu_op    = ADD;
        case (instr_q.r.opcode)
            OPC_OP: begin
                supported = 1'b1;
                case ({instr_q.r.funct7, instr_q.r.funct3})
                    {F7_BASE, 3'b000}: alu_op = ADD;
                    {F7_ALT,  3'b000}: alu_op = SUB;
                    {F7_BASE, 3'b001}: alu_op = SLL;
                    {F7_BASE, 3'b010}: alu_op = SLT;
                    {F7_BASE, 3'b011}: alu_op = SLTU;
                    {F7_BASE, 3'b100}: alu_op = XOR;
                    {F7_BASE, 3'b101}: alu_op = SRL;
                    {F7_ALT,  3'b101}: alu_op = SRA;
                    {F7_BASE, 3'b110}: alu_op = OR;
                    {F7_BASE, 3'b111}: alu_op = AND;
                    default:           supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                supported = 1'b1;
                use_imm   = 1'b1;
                case (instr_q.i.funct3)
                    3'b000: alu_op = ADD;
                    3'b001: begin
                        alu_op    = SLL;
                        supported = (shift_hi == F7_BASE);
                    end
                    3'b010: alu_op = SLT;
                    3'b011: alu_op = SLTU;
                    3'b100: alu_op = XOR;
                    3'b101: begin
                        alu_op    = (shift_hi == F7_ALT) ? SRA : SRL;
                        supported = (shift_hi == F7_BASE) || (shift_hi == F7_ALT);
                    end
                    3'b110: alu_op = OR;
                    default: alu_op = AND;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    // No second source for immediate forms
    assign rs2_addr = use_imm ? '0 : instr_q.r.rs2;

    regfile u_regfile (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_we     (i_wb.valid),
        .i_waddr  (i_wb.rd),
        .i_wdata  (i_wb.result),
        .i_raddr1 (instr_q.r.rs1),
        .i_raddr2 (rs2_addr),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data)
    );

    always_comb begin
        id_ex_d.valid    = instr_valid_q && supported && (instr_q.r.rd != '0);
        id_ex_d.rd       = instr_q.r.rd;
        id_ex_d.rs1      = instr_q.r.rs1;
        id_ex_d.rs2      = rs2_addr;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = {{(XLEN-12){instr_q.i.imm12[11]}}, instr_q.i.imm12};
        id_ex_d.use_imm  = use_imm;
        id_ex_d.alu_op   = alu_op;
    end

    always_ff @(posedge i_clk) begin
        id_ex_q <= id_ex_d;
        if (i_reset) begin
            id_ex_q.valid <= 1'b0;
        end
    end

    assign o_id_ex = id_ex_q;

    a_imm_from_op_imm: assert property (@(posedge i_clk) disable iff (i_reset)
        o_id_ex.use_imm |-> ($past(instr_q.r.opcode) == OPC_OP_IMM));

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  rv_core_pkg::alu_op_e i_op,
    input  rv_core_pkg::word_t   i_a,
    input  rv_core_pkg::word_t   i_b,
    output rv_core_pkg::word_t   o_result
);
    import rv_core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Shift amount from the low 5 bits only
    assign shamt = i_b[4:0];

    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            ADD: begin
                o_result = i_a + i_b;
            end
            SUB: begin
                o_result = i_a - i_b;
            end
            SLL: begin
                o_result = i_a << shamt;
            end
            SLT: begin
                o_result = word_t'(lt_signed);
            end
            SLTU: begin
                o_result = word_t'(lt_unsigned);
            end
            XOR: begin
                o_result = i_a ^ i_b;
            end
            SRL: begin
                o_result = i_a >> shamt;
            end
            SRA: begin
                // Sign bit fills from the left
                o_result = word_t'($signed(i_a) >>> shamt);
            end
            OR: begin
                o_result = i_a | i_b;
            end
            AND: begin
                o_result = i_a & i_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_we,
    input  rv_core_pkg::reg_addr_t i_waddr,
    input  rv_core_pkg::word_t     i_wdata,
    input  rv_core_pkg::reg_addr_t i_raddr1,
    input  rv_core_pkg::reg_addr_t i_raddr2,
    output rv_core_pkg::word_t     o_rdata1,
    output rv_core_pkg::word_t     o_rdata2
);
    import rv_core_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        // Write-through for the instruction two behind the writer
        if (i_we && (addr == i_waddr)) begin
            return i_wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    always_comb begin
        o_rdata1 = read_port(i_raddr1);
        o_rdata2 = read_port(i_raddr2);
    end

    // Decode must have turned rd == x0 into a bubble
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_reset)
        i_we |-> (i_waddr != '0));

endmodule

`default_nettype wire

// File: hw/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_view_t;

    // One instruction word in register or immediate layout
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        logic      use_imm;
        alu_op_e   alu_op;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     result;
    } ex_wb_t;

endpackage

`default_nettype wire
